// ==== verilog/rename_pkg.sv ====
/* Rename subsystem sizes and types */

`default_nettype none

package rename_pkg;

    // architectural and physical register file sizes
    localparam int LOG_REGS = 32;
    localparam int PHY_REGS = 64;

    localparam int LOG_W = 5;
    localparam int PHY_W = 6;

    localparam int PC_W = 32;

    // logical register index
    typedef logic [LOG_W-1:0] log_reg_t;

    // physical register index
    typedef logic [PHY_W-1:0] phy_reg_t;

endpackage

`default_nettype wire

// ==== verilog/free_list.sv ====
/* Physical register free list */

`timescale 1ns/100ps
`default_nettype none

module free_list
(
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic                 alloc_en,
    output rename_pkg::phy_reg_t      alloc_preg,
    output logic                      free_empty,

    input  wire logic                 rel_req,
    input  rename_pkg::phy_reg_t      rel_preg,
    output logic                      rel_ack
);

    import rename_pkg::*;

    logic [PHY_REGS-1:0] free_map;
    logic                rel_accept;

    // lowest set bit wins
    always_comb
    begin
        alloc_preg = '0;
        for (int i = PHY_REGS - 1; i >= 0; i--)
        begin
            if (free_map[i])
                alloc_preg = phy_reg_t'(i);
        end
    end

    assign free_empty = ~|free_map;

    assign rel_accept = rel_req && !rel_ack;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // upper half free, the rest hold the identity mapping
            free_map <= {{(PHY_REGS - LOG_REGS){1'b1}}, {LOG_REGS{1'b0}}};
        end
        else
        begin
            if (alloc_en)
                free_map[alloc_preg] <= 1'b0;
            // p0 is permanently bound to x0
            if (rel_accept && rel_preg != '0)
                free_map[rel_preg] <= 1'b1;
        end
    end

    // four-phase release handshake
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rel_ack <= 1'b0;
        end
        else if (rel_accept)
        begin
            rel_ack <= 1'b1;
        end
        else if (!rel_req)
        begin
            rel_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
/* Logical to physical map table */

`timescale 1ns/100ps
`default_nettype none

module map_table
(
    input  wire logic             clk,
    input  wire logic             rst,

    input  rename_pkg::log_reg_t  rs1_log,
    input  rename_pkg::log_reg_t  rs2_log,
    input  rename_pkg::log_reg_t  rd_log,
    output rename_pkg::phy_reg_t  rs1_phys,
    output rename_pkg::phy_reg_t  rs2_phys,
    output rename_pkg::phy_reg_t  rd_phys,

    input  wire logic             wr_en,
    input  rename_pkg::log_reg_t  wr_log,
    input  rename_pkg::phy_reg_t  wr_phys
);

    import rename_pkg::*;

    phy_reg_t map_q [LOG_REGS];

    // reads see the mapping before any write on this edge
    assign rs1_phys = map_q[rs1_log];
    assign rs2_phys = map_q[rs2_log];
    assign rd_phys  = map_q[rd_log];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < LOG_REGS; i++)
                map_q[i] <= phy_reg_t'(i);
        end
        else if (wr_en && wr_log != '0)
        begin
            map_q[wr_log] <= wr_phys;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/busy_table.sv ====
/* Physical register busy table */

`timescale 1ns/100ps
`default_nettype none

module busy_table
(
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             set_en,
    input  rename_pkg::phy_reg_t  set_preg,

    input  wire logic             wb_valid,
    input  rename_pkg::phy_reg_t  wb_preg,

    input  rename_pkg::phy_reg_t  rs1_preg,
    input  rename_pkg::phy_reg_t  rs2_preg,
    output logic                  rs1_busy,
    output logic                  rs2_busy
);

    import rename_pkg::*;

    logic [PHY_REGS-1:1] busy_q;
    logic [PHY_REGS-1:0] busy;

    // p0 never waits
    assign busy = {busy_q, 1'b0};

    // a writeback this cycle already counts as done
    assign rs1_busy = busy[rs1_preg] && !(wb_valid && wb_preg == rs1_preg);
    assign rs2_busy = busy[rs2_preg] && !(wb_valid && wb_preg == rs2_preg);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= '0;
        end
        else
        begin
            if (wb_valid && wb_preg != '0)
                busy_q[wb_preg] <= 1'b0;
            // set after clear so a new allocation wins
            if (set_en && set_preg != '0)
                busy_q[set_preg] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_stage.sv ====
/* Rename stage control and output register */

`timescale 1ns/100ps
`default_nettype none

module rename_stage
(
    input  wire logic                      clk,
    input  wire logic                      rst,

    input  wire logic                      in_req,
    output logic                           in_ack,
    input  rename_pkg::log_reg_t           in_rd,
    input  wire logic                      in_rd_valid,
    input  rename_pkg::log_reg_t           in_rs1,
    input  wire logic                      in_rs1_valid,
    input  rename_pkg::log_reg_t           in_rs2,
    input  wire logic                      in_rs2_valid,
    input  wire logic [rename_pkg::PC_W-1:0] in_pc,

    output logic                           out_req,
    input  wire logic                      out_ack,
    output rename_pkg::phy_reg_t           out_rd_phys,
    output rename_pkg::phy_reg_t           out_old_phys,
    output rename_pkg::phy_reg_t           out_rs1_phys,
    output logic                           out_rs1_busy,
    output rename_pkg::phy_reg_t           out_rs2_phys,
    output logic                           out_rs2_busy,
    output logic                           out_rd_valid,
    output logic                           out_rs1_valid,
    output logic                           out_rs2_valid,
    output logic [rename_pkg::PC_W-1:0]    out_pc,

    output rename_pkg::log_reg_t           map_rs1_log,
    output rename_pkg::log_reg_t           map_rs2_log,
    output rename_pkg::log_reg_t           map_rd_log,
    input  rename_pkg::phy_reg_t           map_rs1_phys,
    input  rename_pkg::phy_reg_t           map_rs2_phys,
    input  rename_pkg::phy_reg_t           map_rd_phys,
    output logic                           map_wr_en,
    output rename_pkg::log_reg_t           map_wr_log,
    output rename_pkg::phy_reg_t           map_wr_phys,

    output logic                           alloc_en,
    input  rename_pkg::phy_reg_t           alloc_preg,
    input  wire logic                      free_empty,

    output logic                           set_en,
    output rename_pkg::phy_reg_t           set_preg,
    output rename_pkg::phy_reg_t           busy_rs1_preg,
    output rename_pkg::phy_reg_t           busy_rs2_preg,
    input  wire logic                      rs1_busy,
    input  wire logic                      rs2_busy
);

    import rename_pkg::*;

    // state bits are {in_ack, out_req}
    typedef enum logic [1:0] {
        ST_ACCEPT   = 2'b00,
        ST_HOLD_OUT = 2'b01,
        ST_WAIT_IN  = 2'b10,
        ST_HOLD     = 2'b11
    } state_t;

    state_t   state;
    logic     needs_alloc;
    logic     accept;
    phy_reg_t rd_phys_next;
    phy_reg_t old_phys_next;

    assign in_ack  = state[1];
    assign out_req = state[0];

    // x0 and invalid destinations take no register
    assign needs_alloc = in_rd_valid && in_rd != '0;

    assign accept = (state == ST_ACCEPT) && in_req && !out_ack
                    && (!needs_alloc || !free_empty);

    // an invalid source reads x0, hence p0 and never busy
    assign map_rs1_log = in_rs1_valid ? in_rs1 : '0;
    assign map_rs2_log = in_rs2_valid ? in_rs2 : '0;
    assign map_rd_log  = in_rd;

    assign busy_rs1_preg = map_rs1_phys;
    assign busy_rs2_preg = map_rs2_phys;

    assign map_wr_en   = accept && needs_alloc;
    assign map_wr_log  = in_rd;
    assign map_wr_phys = alloc_preg;
    assign alloc_en    = accept && needs_alloc;
    assign set_en      = accept && needs_alloc;
    assign set_preg    = alloc_preg;

    assign rd_phys_next  = needs_alloc ? alloc_preg : '0;
    assign old_phys_next = needs_alloc ? map_rd_phys : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_ACCEPT;
        end
        else
        begin
            case (state)
                ST_ACCEPT:
                    if (accept)
                        state <= ST_HOLD;
                ST_HOLD:
                    if (!in_req && out_ack)
                        state <= ST_ACCEPT;
                    else if (!in_req)
                        state <= ST_HOLD_OUT;
                    else if (out_ack)
                        state <= ST_WAIT_IN;
                ST_HOLD_OUT:
                    if (out_ack)
                        state <= ST_ACCEPT;
                ST_WAIT_IN:
                    if (!in_req)
                        state <= ST_ACCEPT;
                default:
                    state <= ST_ACCEPT;
            endcase
        end
    end

    // renamed uop, held until the next acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_rd_phys   <= rd_phys_next;
            out_old_phys  <= old_phys_next;
            out_rs1_phys  <= map_rs1_phys;
            out_rs1_busy  <= rs1_busy;
            out_rs2_phys  <= map_rs2_phys;
            out_rs2_busy  <= rs2_busy;
            out_rd_valid  <= in_rd_valid;
            out_rs1_valid <= in_rs1_valid;
            out_rs2_valid <= in_rs2_valid;
            out_pc        <= in_pc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_unit.sv ====
/* Register rename unit */

`timescale 1ns/100ps
`default_nettype none

module rename_unit
(
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic                        in_req,
    output logic                             in_ack,
    input  rename_pkg::log_reg_t             in_rd,
    input  wire logic                        in_rd_valid,
    input  rename_pkg::log_reg_t             in_rs1,
    input  wire logic                        in_rs1_valid,
    input  rename_pkg::log_reg_t             in_rs2,
    input  wire logic                        in_rs2_valid,
    input  wire logic [rename_pkg::PC_W-1:0] in_pc,

    output logic                             out_req,
    input  wire logic                        out_ack,
    output rename_pkg::phy_reg_t             out_rd_phys,
    output rename_pkg::phy_reg_t             out_old_phys,
    output rename_pkg::phy_reg_t             out_rs1_phys,
    output logic                             out_rs1_busy,
    output rename_pkg::phy_reg_t             out_rs2_phys,
    output logic                             out_rs2_busy,
    output logic                             out_rd_valid,
    output logic                             out_rs1_valid,
    output logic                             out_rs2_valid,
    output logic [rename_pkg::PC_W-1:0]      out_pc,

    input  wire logic                        rel_req,
    input  rename_pkg::phy_reg_t             rel_preg,
    output logic                             rel_ack,

    input  wire logic                        wb_valid,
    input  rename_pkg::phy_reg_t             wb_preg
);

    import rename_pkg::*;

    log_reg_t map_rs1_log;
    log_reg_t map_rs2_log;
    log_reg_t map_rd_log;
    phy_reg_t map_rs1_phys;
    phy_reg_t map_rs2_phys;
    phy_reg_t map_rd_phys;
    logic     map_wr_en;
    log_reg_t map_wr_log;
    phy_reg_t map_wr_phys;

    logic     alloc_en;
    phy_reg_t alloc_preg;
    logic     free_empty;

    logic     set_en;
    phy_reg_t set_preg;
    phy_reg_t busy_rs1_preg;
    phy_reg_t busy_rs2_preg;
    logic     rs1_busy;
    logic     rs2_busy;

    rename_stage stage0 (.*);

    map_table map0
    (
        .clk      (clk),
        .rst      (rst),
        .rs1_log  (map_rs1_log),
        .rs2_log  (map_rs2_log),
        .rd_log   (map_rd_log),
        .rs1_phys (map_rs1_phys),
        .rs2_phys (map_rs2_phys),
        .rd_phys  (map_rd_phys),
        .wr_en    (map_wr_en),
        .wr_log   (map_wr_log),
        .wr_phys  (map_wr_phys)
    );

    free_list free0
    (
        .clk        (clk),
        .rst        (rst),
        .alloc_en   (alloc_en),
        .alloc_preg (alloc_preg),
        .free_empty (free_empty),
        .rel_req    (rel_req),
        .rel_preg   (rel_preg),
        .rel_ack    (rel_ack)
    );

    // writeback goes straight to the busy bits
    busy_table busy0
    (
        .clk      (clk),
        .rst      (rst),
        .set_en   (set_en),
        .set_preg (set_preg),
        .wb_valid (wb_valid),
        .wb_preg  (wb_preg),
        .rs1_preg (busy_rs1_preg),
        .rs2_preg (busy_rs2_preg),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy)
    );

endmodule

`default_nettype wire

// ==== dv/rename_assert.sv ====
/* Rename handshake assertions */

`timescale 1ns/100ps
`default_nettype none

module rename_assert
(
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        in_req,
    input wire logic                        in_ack,
    input wire logic                        out_req,
    input wire rename_pkg::phy_reg_t        out_rd_phys,
    input wire rename_pkg::phy_reg_t        out_old_phys,
    input wire rename_pkg::phy_reg_t        out_rs1_phys,
    input wire rename_pkg::phy_reg_t        out_rs2_phys,
    input wire logic [rename_pkg::PC_W-1:0] out_pc,
    input wire logic                        rel_req,
    input wire logic                        rel_ack
);

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_req && $past(out_req))
        |-> $stable({out_rd_phys, out_old_phys, out_rs1_phys, out_rs2_phys, out_pc}))
        else $error("out fields changed while out_req was high");

    // acceptance raises both at once
    rise_together: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) == $rose(out_req))
        else $error("in_ack and out_req rose apart");

    rel_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(rel_ack) |-> $past(rel_req))
        else $error("rel_ack rose without rel_req");

endmodule

bind rename_unit rename_assert assert0 (.*);

`default_nettype wire

// ==== dv/rename_tb.sv ====
/* Rename unit directed tests */

`timescale 1ns/100ps
`default_nettype none

module rename_tb;

    import rename_pkg::*;

    localparam int TIMEOUT = 60;

    logic clk;
    logic rst;
    logic in_req, in_ack, in_rd_valid, in_rs1_valid, in_rs2_valid;
    log_reg_t in_rd, in_rs1, in_rs2;
    logic [PC_W-1:0] in_pc, out_pc;
    logic out_req, out_ack, out_rs1_busy, out_rs2_busy;
    logic out_rd_valid, out_rs1_valid, out_rs2_valid;
    phy_reg_t out_rd_phys, out_old_phys, out_rs1_phys, out_rs2_phys;
    logic rel_req, rel_ack, wb_valid;
    phy_reg_t rel_preg, wb_preg;

    // reference model
    phy_reg_t m_map [LOG_REGS];
    logic [PHY_REGS-1:0] m_free;
    logic [PHY_REGS-1:0] m_busy;
    logic [60:0] exp_q [$];

    int errors;
    int timeouts;
    logic [15:0] lfsr;
    string test_name;

    rename_unit dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [60:0] model_uop(log_reg_t rd, logic rdv, log_reg_t rs1,
                                              logic rs1v, log_reg_t rs2, logic rs2v,
                                              logic [PC_W-1:0] pc);
        phy_reg_t p1;
        phy_reg_t p2;
        phy_reg_t nd;
        phy_reg_t od;
        p1 = rs1v ? m_map[rs1] : '0;
        p2 = rs2v ? m_map[rs2] : '0;
        nd = '0;
        od = '0;
        if (rdv && rd != '0)
        begin
            for (int i = PHY_REGS - 1; i > 0; i--)
                if (m_free[i])
                    nd = phy_reg_t'(i);
            od = m_map[rd];
            m_map[rd] = nd;
            m_free[nd] = 1'b0;
            m_busy[nd] = 1'b1;
        end
        return {nd, od, p1, m_busy[p1], p2, m_busy[p2], rdv, rs1v, rs2v, pc};
    endfunction

    function automatic int free_count();
        int n;
        n = 0;
        for (int i = 1; i < PHY_REGS; i++)
            n += int'(m_free[i]);
        return n;
    endfunction

    // fibonacci lfsr, taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    task automatic start_uop(log_reg_t rd, logic rdv, log_reg_t rs1, logic rs1v,
                             log_reg_t rs2, logic rs2v, logic [PC_W-1:0] pc);
        @(posedge clk);
        in_rd <= rd;
        in_rd_valid <= rdv;
        in_rs1 <= rs1;
        in_rs1_valid <= rs1v;
        in_rs2 <= rs2;
        in_rs2_valid <= rs2v;
        in_pc <= pc;
        in_req <= 1'b1;
    endtask

    task automatic complete_uop();
        int cnt;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (!in_ack && cnt < TIMEOUT);
        assert (in_ack) else
        begin
            $display("%s: in_ack never rose", test_name);
            timeouts++;
        end
        in_req <= 1'b0;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (in_ack && cnt < TIMEOUT);
        assert (!in_ack) else
        begin
            $display("%s: in_ack never fell", test_name);
            timeouts++;
        end
    endtask

    task automatic send_uop(log_reg_t rd, logic rdv, log_reg_t rs1, logic rs1v,
                            log_reg_t rs2, logic rs2v, logic [PC_W-1:0] pc);
        exp_q.push_back(model_uop(rd, rdv, rs1, rs1v, rs2, rs2v, pc));
        start_uop(rd, rdv, rs1, rs1v, rs2, rs2v, pc);
        complete_uop();
    endtask

    task automatic recv_uop(input int delay, input bit no_ack);
        int cnt;
        logic [60:0] act;
        logic [60:0] exp;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (!out_req && cnt < TIMEOUT);
        assert (out_req) else
        begin
            $display("%s: out_req never rose", test_name);
            timeouts++;
        end
        repeat (delay)
        begin
            @(posedge clk);
            assert (!(no_ack && in_ack)) else
            begin
                $display("%s: in_ack rose while out_req was pending", test_name);
                errors++;
            end
        end
        act = {out_rd_phys, out_old_phys, out_rs1_phys, out_rs1_busy, out_rs2_phys,
               out_rs2_busy, out_rd_valid, out_rs1_valid, out_rs2_valid, out_pc};
        exp = exp_q.size() > 0 ? exp_q.pop_front() : '0;
        assert (act == exp) else
        begin
            $display("FAILED %s: expected %h actual %h", test_name, exp, act);
            errors++;
        end
        out_ack <= 1'b1;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (out_req && cnt < TIMEOUT);
        assert (!out_req) else
        begin
            $display("%s: out_req never fell", test_name);
            timeouts++;
        end
        out_ack <= 1'b0;
        if (no_ack)
        begin
            // the waiting uop may only be taken once out_ack is low again
            @(posedge clk);
            assert (!in_ack) else
            begin
                $display("%s: in_ack rose before out_ack fell", test_name);
                errors++;
            end
        end
    endtask

    task automatic release_preg(phy_reg_t p);
        int cnt;
        @(posedge clk);
        rel_preg <= p;
        rel_req <= 1'b1;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (!rel_ack && cnt < TIMEOUT);
        assert (rel_ack) else
        begin
            $display("%s: rel_ack never rose", test_name);
            timeouts++;
        end
        rel_req <= 1'b0;
        if (p != '0)
            m_free[p] = 1'b1;
        cnt = 0;
        do
        begin
            @(posedge clk);
            cnt++;
        end
        while (rel_ack && cnt < TIMEOUT);
        assert (!rel_ack) else
        begin
            $display("%s: rel_ack never fell", test_name);
            timeouts++;
        end
    endtask

    task automatic writeback(phy_reg_t p);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_preg <= p;
        @(posedge clk);
        wb_valid <= 1'b0;
        m_busy[p] = 1'b0;
    endtask

    task automatic test_identity();
        test_name = "identity";
        send_uop(5'd0, 1'b0, 5'd5, 1'b1, 5'd7, 1'b1, 32'h100);
        recv_uop(0, 0);
    endtask

    task automatic test_alloc();
        test_name = "alloc_order";
        send_uop(5'd3, 1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 32'h104);
        recv_uop(1, 0);
        send_uop(5'd3, 1'b1, 5'd3, 1'b1, 5'd0, 1'b0, 32'h108);
        recv_uop(0, 0);
        send_uop(5'd9, 1'b1, 5'd9, 1'b1, 5'd3, 1'b1, 32'h10c);
        recv_uop(2, 0);
        send_uop(5'd0, 1'b0, 5'd3, 1'b1, 5'd9, 1'b1, 32'h110);
        recv_uop(0, 0);
    endtask

    task automatic test_writeback();
        test_name = "writeback";
        writeback(6'd33);
        send_uop(5'd0, 1'b0, 5'd3, 1'b1, 5'd0, 1'b0, 32'h114);
        recv_uop(0, 0);
        // writeback on the same edge as the read of x9
        test_name = "writeback_bypass";
        m_busy[m_map[9]] = 1'b0;
        exp_q.push_back(model_uop(5'd0, 1'b0, 5'd9, 1'b1, 5'd0, 1'b0, 32'h118));
        start_uop(5'd0, 1'b0, 5'd9, 1'b1, 5'd0, 1'b0, 32'h118);
        wb_valid <= 1'b1;
        wb_preg <= m_map[9];
        @(posedge clk);
        wb_valid <= 1'b0;
        complete_uop();
        recv_uop(0, 0);
    endtask

    task automatic test_x0_invalid();
        test_name = "x0_invalid";
        send_uop(5'd0, 1'b1, 5'd12, 1'b0, 5'd3, 1'b0, 32'h11c);
        recv_uop(0, 0);
        send_uop(5'd4, 1'b1, 5'd0, 1'b1, 5'd0, 1'b0, 32'h120);
        recv_uop(0, 0);
        // x4 now maps to a busy register
        send_uop(5'd0, 1'b0, 5'd4, 1'b0, 5'd4, 1'b0, 32'h124);
        recv_uop(0, 0);
    endtask

    task automatic test_exhaust();
        int n;
        int cnt;
        test_name = "exhaust";
        n = 0;
        while (free_count() > 0)
        begin
            send_uop(log_reg_t'(1 + n % 31), 1'b1, 5'd2, 1'b1, 5'd0, 1'b0, 32'h200 + n);
            recv_uop(0, 0);
            n++;
        end
        // a writer must stall now
        start_uop(5'd6, 1'b1, 5'd1, 1'b1, 5'd0, 1'b0, 32'h300);
        cnt = 0;
        while (cnt < 20)
        begin
            @(posedge clk);
            cnt++;
            assert (!in_ack) else
            begin
                $display("%s: uop accepted with an empty free list", test_name);
                errors++;
            end
        end
        release_preg(6'd40);
        exp_q.push_back(model_uop(5'd6, 1'b1, 5'd1, 1'b1, 5'd0, 1'b0, 32'h300));
        complete_uop();
        recv_uop(0, 0);
        test_name = "empty_no_dest";
        send_uop(5'd0, 1'b0, 5'd6, 1'b1, 5'd7, 1'b1, 32'h304);
        recv_uop(0, 0);
    endtask

    task automatic test_backpressure();
        int d;
        test_name = "backpressure";
        release_preg(6'd50);
        release_preg(6'd51);
        writeback(m_map[6]);
        send_uop(5'd0, 1'b0, 5'd6, 1'b1, 5'd0, 1'b0, 32'h400);
        for (int i = 0; i < 6; i++)
        begin
            d = rand_bits(3);
            exp_q.push_back(model_uop(log_reg_t'(8 + i % 2), i < 2, 5'd6, 1'b1,
                                      log_reg_t'(8 + i % 2), 1'b1, 32'h404 + i));
            start_uop(log_reg_t'(8 + i % 2), i < 2, 5'd6, 1'b1,
                      log_reg_t'(8 + i % 2), 1'b1, 32'h404 + i);
            recv_uop(d + 1, 1);
            complete_uop();
        end
        d = rand_bits(3);
        recv_uop(d, 0);
    endtask

    initial
    begin
        rst = 1'b1;
        in_req = 1'b0;
        in_rd = '0;
        in_rd_valid = 1'b0;
        in_rs1 = '0;
        in_rs1_valid = 1'b0;
        in_rs2 = '0;
        in_rs2_valid = 1'b0;
        in_pc = '0;
        out_ack = 1'b0;
        rel_req = 1'b0;
        rel_preg = '0;
        wb_valid = 1'b0;
        wb_preg = '0;
        errors = 0;
        timeouts = 0;
        lfsr = 16'd36;
        for (int i = 0; i < LOG_REGS; i++)
            m_map[i] = phy_reg_t'(i);
        m_free = {{(PHY_REGS - LOG_REGS){1'b1}}, {LOG_REGS{1'b0}}};
        m_busy = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_identity();
        test_alloc();
        test_writeback();
        test_x0_invalid();
        test_exhaust();
        test_backpressure();

        $display("check errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/busy_table.sv
verilog/rename_stage.sv
verilog/rename_unit.sv
dv/rename_assert.sv
dv/rename_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the rename unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rename_tb -o rename_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/rename_sim)
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
